//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam int OPC_LSB   = 26; // field start bits
  localparam int RS_LSB    = 21;
  localparam int RT_LSB    = 16;
  localparam int RD_LSB    = 11;
  localparam int SHAMT_LSB = 6;
  localparam int FIELD6_W  = 6;  // opcode and funct width
  localparam int IMM_W     = 16; // imm and funct sit at bit 0
  localparam int TARGET_W  = 26;

  localparam logic [5:0]
    OPC_SPECIAL = 6'h00, OPC_REGIMM = 6'h01, OPC_J     = 6'h02, OPC_JAL   = 6'h03,
    OPC_BEQ     = 6'h04, OPC_BNE    = 6'h05, OPC_BLEZ  = 6'h06, OPC_BGTZ  = 6'h07,
    OPC_ADDI    = 6'h08, OPC_ADDIU  = 6'h09, OPC_SLTI  = 6'h0a, OPC_SLTIU = 6'h0b,
    OPC_ANDI    = 6'h0c, OPC_ORI    = 6'h0d, OPC_XORI  = 6'h0e, OPC_LUI   = 6'h0f,
    OPC_LB      = 6'h20, OPC_LH     = 6'h21, OPC_LW    = 6'h23, OPC_LBU   = 6'h24,
    OPC_LHU     = 6'h25, OPC_SB     = 6'h28, OPC_SH    = 6'h29, OPC_SW    = 6'h2b;

  localparam logic [5:0]
    FN_SLL  = 6'd0,  FN_SRL  = 6'd2,  FN_SRA  = 6'd3,  FN_SLLV = 6'd4,
    FN_SRLV = 6'd6,  FN_SRAV = 6'd7,  FN_JR   = 6'd8,  FN_JALR = 6'd9,
    FN_ADD  = 6'd32, FN_ADDU = 6'd33, FN_SUB  = 6'd34, FN_SUBU = 6'd35,
    FN_AND  = 6'd36, FN_OR   = 6'd37, FN_XOR  = 6'd38, FN_NOR  = 6'd39,
    FN_SLT  = 6'd42, FN_SLTU = 6'd43;

  localparam logic [4:0]
    RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11;

  localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // ra

  typedef enum logic [3:0] {
    OP_PASS_A, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_LUI
  } alu_op_t;

  typedef enum logic {RES_ALU, RES_SET} alu_res_t;

  typedef enum logic [1:0] {OP_LS_WORD, OP_LS_HALFWORD, OP_LS_BYTE} ls_op_t;

  typedef enum logic [2:0] {
    COND_UNCONDITIONAL, COND_EQ, COND_NE, COND_LT, COND_GE, COND_LE, COND_GT
  } cond_t;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;
  import isa_pkg::*;

  typedef enum logic [1:0] {
    FWD_NONE, FWD_FROM_EXMEM, FWD_FROM_MEMWB, FWD_FROM_MEMWB_LATE
  } fwd_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst_word;
    logic            valid;
  } fetch_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] reg_addr;
    logic                  valid;
  } dest_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] A_reg;
    logic                  A_reg_valid;
    logic [REG_ADDR_W-1:0] B_reg;
    logic                  B_reg_valid;
    logic                  B_need_late; // store data only used in MEM
  } src_t;

  typedef struct packed {
    alu_op_t               alu_op;
    alu_res_t              alu_res_sel;
    logic                  alu_set_u;
    logic [REG_ADDR_W-1:0] shamt;
    ls_op_t                ls_op;
    logic                  ls_sext;
    cond_t                 branch_cond;
    logic                  alu_inst;
    logic                  load_inst;
    logic                  store_inst;
    logic                  jmp_inst;
    logic                  branch_inst;
    dest_t                 dest;
    logic [XLEN-1:0]       imm;
    logic                  imm_valid;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    ctrl_t           ctrl;
    logic [XLEN-1:0] A;
    logic [XLEN-1:0] B;
    fwd_t            A_fwd_from;
    fwd_t            B_fwd_from;
  } id_ex_t;

  typedef struct packed {
    logic                  en;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

//--- logic/reg_file.sv
module reg_file (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr1,
  input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr2,
  output logic [isa_pkg::XLEN-1:0]       rd_data1,
  output logic [isa_pkg::XLEN-1:0]       rd_data2,
  input  pipe_pkg::wb_t                  wb
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != '0)) begin // r0 stays zero
      regs[wb.addr] <= wb.data;
    end
  end

  // no bypass so a write shows up on the next cycle
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

//--- logic/inst_decoder.sv
module inst_decoder (
  input  pipe_pkg::fetch_t fetch,
  output pipe_pkg::ctrl_t  ctrl,
  output pipe_pkg::src_t   src
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [FIELD6_W-1:0]   opc;
  logic [FIELD6_W-1:0]   funct;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] shamt_f;
  logic [IMM_W-1:0]      imm16;
  logic [TARGET_W-1:0]   target;
  logic [XLEN-1:0]       pc_plus_4;
  logic                  imm_sext;
  logic                  iformat;
  logic                  jformat;
  logic                  known;

  assign opc       = fetch.inst_word[OPC_LSB +: FIELD6_W];
  assign rs        = fetch.inst_word[RS_LSB +: REG_ADDR_W];
  assign rt        = fetch.inst_word[RT_LSB +: REG_ADDR_W];
  assign rd        = fetch.inst_word[RD_LSB +: REG_ADDR_W];
  assign shamt_f   = fetch.inst_word[SHAMT_LSB +: REG_ADDR_W];
  assign funct     = fetch.inst_word[FIELD6_W-1:0];
  assign imm16     = fetch.inst_word[IMM_W-1:0];
  assign target    = fetch.inst_word[TARGET_W-1:0];
  assign pc_plus_4 = fetch.pc + XLEN'(4);

  always_comb begin
    ctrl               = '0;
    ctrl.dest.reg_addr = rt; // I-type default
    ctrl.dest.valid    = 1'b1;
    src                = '0;
    src.A_reg          = rs;
    src.B_reg          = rt;
    imm_sext           = 1'b0;
    iformat            = 1'b1;
    jformat            = 1'b0;
    known              = 1'b1;

    case (opc)
      OPC_SPECIAL: begin
        iformat            = 1'b0;
        ctrl.dest.reg_addr = rd;
        ctrl.shamt         = shamt_f;
        ctrl.alu_inst      = 1'b1;
        src.A_reg_valid    = 1'b1;
        src.B_reg_valid    = 1'b1;
        case (funct)
          FN_SLL: begin
            ctrl.alu_op     = OP_SLL;
            src.A_reg_valid = 1'b0; // shamt form reads only rt
          end
          FN_SRL: begin
            ctrl.alu_op     = OP_SRL;
            src.A_reg_valid = 1'b0;
          end
          FN_SRA: begin
            ctrl.alu_op     = OP_SRA;
            src.A_reg_valid = 1'b0;
          end
          FN_SLLV: ctrl.alu_op = OP_SLL;
          FN_SRLV: ctrl.alu_op = OP_SRL;
          FN_SRAV: ctrl.alu_op = OP_SRA;
          FN_JR, FN_JALR: begin
            ctrl.alu_inst   = 1'b0;
            ctrl.jmp_inst   = 1'b1;
            ctrl.dest.valid = (funct == FN_JALR); // jalr links to rd
            src.B_reg_valid = 1'b0;
          end
          FN_ADD, FN_ADDU: ctrl.alu_op = OP_ADD;
          FN_SUB, FN_SUBU: ctrl.alu_op = OP_SUB;
          FN_AND: ctrl.alu_op = OP_AND;
          FN_OR:  ctrl.alu_op = OP_OR;
          FN_XOR: ctrl.alu_op = OP_XOR;
          FN_NOR: ctrl.alu_op = OP_NOR;
          FN_SLT, FN_SLTU: begin
            ctrl.alu_op      = OP_SUB;
            ctrl.alu_res_sel = RES_SET;
            ctrl.alu_set_u   = (funct == FN_SLTU);
          end
          default: known = 1'b0;
        endcase
      end
      OPC_REGIMM: begin
        ctrl.branch_inst   = 1'b1;
        src.A_reg_valid    = 1'b1;
        ctrl.dest.reg_addr = LINK_REG;
        ctrl.dest.valid    = (rt == RT_BLTZAL) || (rt == RT_BGEZAL);
        case (rt)
          RT_BLTZ, RT_BLTZAL: ctrl.branch_cond = COND_LT;
          RT_BGEZ, RT_BGEZAL: ctrl.branch_cond = COND_GE;
          default:            known = 1'b0;
        endcase
      end
      OPC_J, OPC_JAL: begin
        iformat            = 1'b0;
        jformat            = 1'b1;
        ctrl.jmp_inst      = 1'b1;
        ctrl.dest.reg_addr = LINK_REG;
        ctrl.dest.valid    = (opc == OPC_JAL);
      end
      OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ: begin
        ctrl.branch_inst = 1'b1;
        ctrl.dest.valid  = 1'b0;
        src.A_reg_valid  = 1'b1;
        src.B_reg_valid  = (opc == OPC_BEQ) || (opc == OPC_BNE); // blez/bgtz compare to zero
        case (opc)
          OPC_BEQ:  ctrl.branch_cond = COND_EQ;
          OPC_BNE:  ctrl.branch_cond = COND_NE;
          OPC_BLEZ: ctrl.branch_cond = COND_LE;
          default:  ctrl.branch_cond = COND_GT;
        endcase
      end
      OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
        imm_sext         = 1'b1;
        ctrl.alu_inst    = 1'b1;
        src.A_reg_valid  = 1'b1;
        ctrl.alu_op      = (opc == OPC_ADDI || opc == OPC_ADDIU) ? OP_ADD : OP_SUB;
        ctrl.alu_res_sel = (opc == OPC_SLTI || opc == OPC_SLTIU) ? RES_SET : RES_ALU;
        ctrl.alu_set_u   = (opc == OPC_SLTIU);
      end
      OPC_ANDI, OPC_ORI, OPC_XORI: begin // zero-extended imm
        ctrl.alu_inst   = 1'b1;
        src.A_reg_valid = 1'b1;
        case (opc)
          OPC_ANDI: ctrl.alu_op = OP_AND;
          OPC_ORI:  ctrl.alu_op = OP_OR;
          default:  ctrl.alu_op = OP_XOR;
        endcase
      end
      OPC_LUI: begin
        ctrl.alu_inst = 1'b1;
        ctrl.alu_op   = OP_LUI;
      end
      OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU: begin
        ctrl.alu_op     = OP_ADD; // address calc
        imm_sext        = 1'b1;
        ctrl.load_inst  = 1'b1;
        src.A_reg_valid = 1'b1;
        ctrl.ls_sext    = (opc == OPC_LB) || (opc == OPC_LH);
        if (opc == OPC_LB || opc == OPC_LBU) begin
          ctrl.ls_op = OP_LS_BYTE;
        end else if (opc == OPC_LH || opc == OPC_LHU) begin
          ctrl.ls_op = OP_LS_HALFWORD;
        end
      end
      OPC_SB, OPC_SH, OPC_SW: begin
        ctrl.alu_op     = OP_ADD;
        imm_sext        = 1'b1;
        ctrl.store_inst = 1'b1;
        ctrl.dest.valid = 1'b0;
        src.A_reg_valid = 1'b1;
        src.B_reg_valid = 1'b1;
        src.B_need_late = 1'b1;
        if (opc == OPC_SB) begin
          ctrl.ls_op = OP_LS_BYTE;
        end else if (opc == OPC_SH) begin
          ctrl.ls_op = OP_LS_HALFWORD;
        end
      end
      default: known = 1'b0;
    endcase

    if (!known) begin // decode as no-op
      ctrl.alu_inst    = 1'b0;
      ctrl.branch_inst = 1'b0;
      ctrl.dest.valid  = 1'b0;
      src.A_reg_valid  = 1'b0;
      src.B_reg_valid  = 1'b0;
    end

    if (ctrl.jmp_inst) begin
      ctrl.imm = {pc_plus_4[XLEN-1 -: 4], target, 2'b00};
    end else if (ctrl.branch_inst) begin
      ctrl.imm = pc_plus_4 + {{(XLEN-IMM_W-2){imm16[IMM_W-1]}}, imm16, 2'b00};
    end else if (imm_sext) begin
      ctrl.imm = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
    end else begin
      ctrl.imm = {{(XLEN-IMM_W){1'b0}}, imm16};
    end
    ctrl.imm_valid = known && (iformat || jformat);
  end

endmodule

//--- logic/hazard_unit.sv
module hazard_unit (
  input  pipe_pkg::src_t  src,
  input  pipe_pkg::dest_t ex_dest,
  input  logic            ex_load,
  input  pipe_pkg::dest_t mem_dest,
  output pipe_pkg::fwd_t  A_fwd_from,
  output pipe_pkg::fwd_t  B_fwd_from,
  output logic            stall
);

  import pipe_pkg::*;

  logic a_match_ex;
  logic a_match_mem;
  logic b_match_ex;
  logic b_match_mem;

  assign a_match_ex  = src.A_reg_valid && ex_dest.valid && (src.A_reg == ex_dest.reg_addr);
  assign b_match_ex  = src.B_reg_valid && ex_dest.valid && (src.B_reg == ex_dest.reg_addr);
  assign a_match_mem = src.A_reg_valid && mem_dest.valid && (src.A_reg == mem_dest.reg_addr);
  assign b_match_mem = src.B_reg_valid && mem_dest.valid && (src.B_reg == mem_dest.reg_addr);

  // youngest producer wins
  always_comb begin
    if (a_match_ex) begin
      A_fwd_from = FWD_FROM_EXMEM;
    end else if (a_match_mem) begin
      A_fwd_from = FWD_FROM_MEMWB;
    end else begin
      A_fwd_from = FWD_NONE;
    end
  end

  always_comb begin
    if (b_match_ex) begin
      B_fwd_from = ex_load ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM; // load data only in MEM
    end else if (b_match_mem) begin
      B_fwd_from = FWD_FROM_MEMWB;
    end else begin
      B_fwd_from = FWD_NONE;
    end
  end

  // load-use stall unless B is only needed by the store in MEM
  assign stall = ex_load && (a_match_ex || (b_match_ex && !src.B_need_late));

endmodule

//--- logic/id_ex_reg.sv
module id_ex_reg (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [isa_pkg::XLEN-1:0] pc,
  input  pipe_pkg::ctrl_t          ctrl,
  input  logic [isa_pkg::XLEN-1:0] A,
  input  logic [isa_pkg::XLEN-1:0] B,
  input  pipe_pkg::fwd_t           A_fwd_from,
  input  pipe_pkg::fwd_t           B_fwd_from,
  input  logic                     stall,
  input  logic                     fetch_valid,
  output pipe_pkg::id_ex_t         id_ex
);

  import pipe_pkg::*;

  ctrl_t bubble_ctrl;
  logic  insert_bubble;

  assign insert_bubble = stall || !fetch_valid;

  always_comb begin
    bubble_ctrl             = ctrl;
    bubble_ctrl.dest.valid  = 1'b0;
    bubble_ctrl.alu_inst    = 1'b0;
    bubble_ctrl.load_inst   = 1'b0;
    bubble_ctrl.store_inst  = 1'b0;
    bubble_ctrl.jmp_inst    = 1'b0;
    bubble_ctrl.branch_inst = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex.pc         <= pc;
      id_ex.ctrl       <= insert_bubble ? bubble_ctrl : ctrl;
      id_ex.A          <= A;
      id_ex.B          <= B;
      id_ex.A_fwd_from <= A_fwd_from;
      id_ex.B_fwd_from <= B_fwd_from;
    end
  end

endmodule

//--- logic/decode_stage.sv
module decode_stage (
  input  logic             clock,
  input  logic             reset,
  input  pipe_pkg::fetch_t fetch,
  input  pipe_pkg::wb_t    wb,
  input  pipe_pkg::dest_t  ex_mem_dest,
  output pipe_pkg::id_ex_t id_ex,
  output logic             stall
);

  import isa_pkg::*;
  import pipe_pkg::*;

  ctrl_t           ctrl;
  src_t            src;
  logic [XLEN-1:0] rd_data1;
  logic [XLEN-1:0] rd_data2;
  fwd_t            A_fwd_from;
  fwd_t            B_fwd_from;

  reg_file u_reg_file (
    .clock    (clock),
    .reset    (reset),
    .rd_addr1 (fetch.inst_word[RS_LSB +: REG_ADDR_W]), // rs
    .rd_addr2 (fetch.inst_word[RT_LSB +: REG_ADDR_W]), // rt
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2),
    .wb       (wb)
  );

  inst_decoder u_inst_decoder (
    .fetch (fetch),
    .ctrl  (ctrl),
    .src   (src)
  );

  hazard_unit u_hazard_unit (
    .src        (src),
    .ex_dest    (id_ex.ctrl.dest),
    .ex_load    (id_ex.ctrl.load_inst),
    .mem_dest   (ex_mem_dest),
    .A_fwd_from (A_fwd_from),
    .B_fwd_from (B_fwd_from),
    .stall      (stall)
  );

  id_ex_reg u_id_ex_reg (
    .clock       (clock),
    .reset       (reset),
    .pc          (fetch.pc),
    .ctrl        (ctrl),
    .A           (rd_data1),
    .B           (rd_data2),
    .A_fwd_from  (A_fwd_from),
    .B_fwd_from  (B_fwd_from),
    .stall       (stall),
    .fetch_valid (fetch.valid),
    .id_ex       (id_ex)
  );

endmodule

//--- verification/decode_stage_props.sv
module decode_stage_props (
  input logic                     clock,
  input logic                     reset,
  input logic                     stall,
  input logic [isa_pkg::XLEN-1:0] pc,
  input pipe_pkg::ctrl_t          ctrl,
  input pipe_pkg::id_ex_t         id_ex
);
  timeunit 1ns;
  timeprecision 1ps;

  import pipe_pkg::*;

  logic ex_busy; // any class flag or a live dest in EX

  assign ex_busy = id_ex.ctrl.dest.valid || id_ex.ctrl.alu_inst || id_ex.ctrl.load_inst ||
                   id_ex.ctrl.store_inst || id_ex.ctrl.jmp_inst || id_ex.ctrl.branch_inst;

  stall_gives_bubble: assert property (@(posedge clock) disable iff (reset)
    stall |=> !ex_busy)
    else $error("no bubble in ID/EX after a stalled cycle");

  // same word again finds a bubble in EX
  stall_single_cycle: assert property (@(posedge clock) disable iff (reset)
    stall |=> !(stall && $stable(pc) && $stable(ctrl)))
    else $error("stall held two cycles on the same fetch word");

  clear_after_reset: assert property (@(posedge clock)
    $past(reset) |-> !ex_busy)
    else $error("class flags set right after reset");

endmodule

bind id_ex_reg decode_stage_props props_i (
  .clock (clock),
  .reset (reset),
  .stall (stall),
  .pc    (pc),
  .ctrl  (ctrl),
  .id_ex (id_ex)
);

//--- verification/decode_stage_tb.sv
module decode_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int TOTAL_CYCLES = 40 + 40 + 30 + 30 + 20 + 20; // summed per-test cycle budgets
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TOTAL_CYCLES) * 10 + 500;

  logic       clock;
  logic       reset;
  fetch_t     fetch;
  wb_t        wb;
  dest_t      ex_mem_dest;
  id_ex_t     id_ex;
  logic       stall;

  integer          seed = 9;
  logic [XLEN-1:0] model_regs [32];
  logic [XLEN-1:0] cur_pc;
  id_ex_t          exp_id_ex;
  string           test_name;
  int              test_errs;
  int              total_errs;
  int              tests_run;
  int              stall_cycles;
  logic [4:0]      rx;

  decode_stage dut_i (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .wb          (wb),
    .ex_mem_dest (ex_mem_dest),
    .id_ex       (id_ex),
    .stall       (stall)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic check_word(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_ctrl(string what, ctrl_t exp, ctrl_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_fwd(string what, fwd_t exp, fwd_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
      test_errs++;
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  function automatic ls_op_t size_of(logic [1:0] sz);
    if (sz == 2'd0) return OP_LS_BYTE;
    if (sz == 2'd1) return OP_LS_HALFWORD;
    return OP_LS_WORD;
  endfunction

  // expected ID/EX contents and stall for one fetch word
  function automatic void ref_decode(input fetch_t f, input id_ex_t prev, input dest_t mem,
                                     output id_ex_t exp, output logic exp_stall);
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
    logic [31:0] pc4;
    ctrl_t       c;
    logic        known;
    logic        a_v;
    logic        b_v;
    logic        late;
    logic        sext;
    logic        a_ex;
    logic        b_ex;
    logic        a_mem;
    logic        b_mem;
    opc   = f.inst_word[31:26];
    fn    = f.inst_word[5:0];
    rs    = f.inst_word[25:21];
    rt    = f.inst_word[20:16];
    imm16 = f.inst_word[15:0];
    pc4   = f.pc + 32'd4;
    c     = '0;
    c.dest.reg_addr = rt;
    c.dest.valid    = 1'b1;
    known = 1'b1;
    a_v   = 1'b1; // most forms read rs
    b_v   = 1'b0;
    late  = 1'b0;
    sext  = 1'b0;
    case (opc)
      OPC_SPECIAL: begin
        c.dest.reg_addr = f.inst_word[15:11];
        c.shamt         = f.inst_word[10:6];
        c.alu_inst      = 1'b1;
        b_v             = 1'b1;
        if (fn[5:3] == 3'b000 && fn[1:0] != 2'b01) begin // shift group
          a_v      = fn[2];
          c.alu_op = (fn[1:0] == 2'd0) ? OP_SLL : (fn[1:0] == 2'd2) ? OP_SRL : OP_SRA;
        end else begin
          case (fn)
            FN_JR, FN_JALR: begin
              c.alu_inst   = 1'b0;
              c.jmp_inst   = 1'b1;
              c.dest.valid = fn[0];
              b_v          = 1'b0;
            end
            FN_ADD, FN_ADDU: c.alu_op = OP_ADD;
            FN_SUB, FN_SUBU: c.alu_op = OP_SUB;
            FN_AND: c.alu_op = OP_AND;
            FN_OR:  c.alu_op = OP_OR;
            FN_XOR: c.alu_op = OP_XOR;
            FN_NOR: c.alu_op = OP_NOR;
            FN_SLT, FN_SLTU: begin
              c.alu_op      = OP_SUB;
              c.alu_res_sel = RES_SET;
              c.alu_set_u   = fn[0];
            end
            default: known = 1'b0;
          endcase
        end
      end
      OPC_REGIMM: begin
        c.branch_inst   = 1'b1;
        c.dest.reg_addr = LINK_REG;
        c.dest.valid    = rt[4]; // link forms
        known           = (rt[3:1] == 3'b000);
        if (known) c.branch_cond = rt[0] ? COND_GE : COND_LT;
      end
      OPC_J, OPC_JAL: begin
        a_v             = 1'b0;
        c.jmp_inst      = 1'b1;
        c.dest.reg_addr = LINK_REG;
        c.dest.valid    = opc[0];
      end
      OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ: begin
        c.branch_inst = 1'b1;
        c.dest.valid  = 1'b0;
        b_v           = !opc[1];
        case (opc)
          OPC_BEQ:  c.branch_cond = COND_EQ;
          OPC_BNE:  c.branch_cond = COND_NE;
          OPC_BLEZ: c.branch_cond = COND_LE;
          default:  c.branch_cond = COND_GT;
        endcase
      end
      OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
        sext          = 1'b1;
        c.alu_inst    = 1'b1;
        c.alu_op      = opc[1] ? OP_SUB : OP_ADD;
        c.alu_res_sel = opc[1] ? RES_SET : RES_ALU;
        c.alu_set_u   = opc[1] && opc[0];
      end
      OPC_ANDI, OPC_ORI, OPC_XORI: begin
        c.alu_inst = 1'b1;
        c.alu_op   = opc[1] ? OP_XOR : (opc[0] ? OP_OR : OP_AND);
      end
      OPC_LUI: begin
        a_v        = 1'b0;
        c.alu_inst = 1'b1;
        c.alu_op   = OP_LUI;
      end
      OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU: begin
        sext        = 1'b1;
        c.alu_op    = OP_ADD;
        c.load_inst = 1'b1;
        c.ls_op     = size_of(opc[1:0]);
        c.ls_sext   = !opc[2] && (opc[1:0] != 2'd3);
      end
      OPC_SB, OPC_SH, OPC_SW: begin
        sext         = 1'b1;
        c.alu_op     = OP_ADD;
        c.store_inst = 1'b1;
        c.dest.valid = 1'b0;
        c.ls_op      = size_of(opc[1:0]);
        b_v          = 1'b1;
        late         = 1'b1;
      end
      default: known = 1'b0;
    endcase
    if (!known) begin
      c.alu_inst    = 1'b0;
      c.branch_inst = 1'b0;
      c.dest.valid  = 1'b0;
      a_v           = 1'b0;
      b_v           = 1'b0;
    end
    if (c.jmp_inst) c.imm = {pc4[31:28], f.inst_word[25:0], 2'b00};
    else if (c.branch_inst) c.imm = pc4 + {{14{imm16[15]}}, imm16, 2'b00};
    else if (sext) c.imm = {{16{imm16[15]}}, imm16};
    else c.imm = {16'd0, imm16};
    c.imm_valid = known && (opc != OPC_SPECIAL);

    a_ex  = a_v && prev.ctrl.dest.valid && (rs == prev.ctrl.dest.reg_addr);
    b_ex  = b_v && prev.ctrl.dest.valid && (rt == prev.ctrl.dest.reg_addr);
    a_mem = a_v && mem.valid && (rs == mem.reg_addr);
    b_mem = b_v && mem.valid && (rt == mem.reg_addr);
    exp.A_fwd_from = a_ex ? FWD_FROM_EXMEM : (a_mem ? FWD_FROM_MEMWB : FWD_NONE);
    if (b_ex) exp.B_fwd_from = prev.ctrl.load_inst ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM;
    else exp.B_fwd_from = b_mem ? FWD_FROM_MEMWB : FWD_NONE;
    exp_stall = prev.ctrl.load_inst && (a_ex || (b_ex && !late));

    if (exp_stall || !f.valid) begin // bubble
      c.dest.valid  = 1'b0;
      c.alu_inst    = 1'b0;
      c.load_inst   = 1'b0;
      c.store_inst  = 1'b0;
      c.jmp_inst    = 1'b0;
      c.branch_inst = 1'b0;
    end
    exp.pc   = f.pc;
    exp.ctrl = c;
    exp.A    = model_regs[rs];
    exp.B    = model_regs[rt];
  endfunction

  always @(negedge clock) begin
    id_ex_t nxt;
    logic   nxt_stall;
    if (reset) begin
      exp_id_ex = '0;
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
    end else begin
      check_word("pc", exp_id_ex.pc, id_ex.pc);
      check_ctrl("ctrl", exp_id_ex.ctrl, id_ex.ctrl);
      check_word("imm", exp_id_ex.ctrl.imm, id_ex.ctrl.imm);
      check_word("A", exp_id_ex.A, id_ex.A);
      check_word("B", exp_id_ex.B, id_ex.B);
      check_fwd("A_fwd_from", exp_id_ex.A_fwd_from, id_ex.A_fwd_from);
      check_fwd("B_fwd_from", exp_id_ex.B_fwd_from, id_ex.B_fwd_from);
      ref_decode(fetch, exp_id_ex, ex_mem_dest, nxt, nxt_stall);
      check_bit("stall", nxt_stall, stall);
      if (wb.en && wb.addr != 5'd0) model_regs[wb.addr] = wb.data; // seen from next cycle
      exp_id_ex = nxt;
    end
  end

  function automatic logic [31:0] r_inst(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                         logic [4:0] rd, logic [4:0] sh);
    return {OPC_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] imm_inst(logic [5:0] opc, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
    return {opc, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jump_inst(logic [5:0] opc, logic [25:0] target);
    return {opc, target};
  endfunction

  function automatic dest_t producer(logic [4:0] addr);
    dest_t d;
    d.reg_addr = addr;
    d.valid    = 1'b1;
    return d;
  endfunction

  // fetch holds the word while stall is high
  task automatic issue(logic [31:0] word, dest_t mem);
    @(posedge clock);
    fetch       <= '{pc: cur_pc, inst_word: word, valid: 1'b1};
    wb          <= '0;
    ex_mem_dest <= mem;
    @(negedge clock);
    while (stall) begin
      stall_cycles++;
      @(negedge clock);
    end
    cur_pc = cur_pc + 32'd4;
  endtask

  task automatic write_reg(logic [4:0] addr, logic [31:0] data);
    @(posedge clock);
    wb          <= '{en: 1'b1, addr: addr, data: data};
    fetch.valid <= 1'b0;
    ex_mem_dest <= '0;
  endtask

  task automatic start_test(string name);
    test_name    = name;
    test_errs    = 0;
    stall_cycles = 0;
  endtask

  task automatic finish_test();
    repeat (2) begin
      @(posedge clock);
      fetch.valid <= 1'b0;
      wb          <= '0;
    end
    @(negedge clock);
    $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed", test_errs);
    total_errs += test_errs;
    tests_run++;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run hung and did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    fetch       = '0;
    wb          = '0;
    ex_mem_dest = '0;
    cur_pc      = 32'h0040_0000;
    total_errs  = 0;
    tests_run   = 0;
    start_test("reset");
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    start_test("rtype");
    for (int r = 1; r < 8; r++) write_reg(5'(r), $random(seed));
    issue(r_inst(FN_ADD, 5'd1, 5'd2, 5'd10, 5'd0), '0);
    issue(r_inst(FN_SUBU, 5'd3, 5'd4, 5'd11, 5'd0), '0);
    issue(r_inst(FN_AND, 5'd5, 5'd6, 5'd12, 5'd0), '0);
    issue(r_inst(FN_OR, 5'd7, 5'd1, 5'd13, 5'd0), '0);
    issue(r_inst(FN_XOR, 5'd2, 5'd3, 5'd14, 5'd0), '0);
    issue(r_inst(FN_NOR, 5'd4, 5'd5, 5'd15, 5'd0), '0);
    issue(r_inst(FN_SLL, 5'd0, 5'd3, 5'd16, 5'd5), '0);
    issue(r_inst(FN_SRA, 5'd0, 5'd4, 5'd17, 5'd31), '0);
    issue(r_inst(FN_SRLV, 5'd1, 5'd6, 5'd18, 5'd0), '0);
    issue(r_inst(FN_SLT, 5'd2, 5'd7, 5'd19, 5'd0), '0);
    issue(r_inst(FN_SLTU, 5'd3, 5'd1, 5'd20, 5'd0), '0);
    issue(r_inst(FN_JR, 5'd5, 5'd0, 5'd0, 5'd0), '0);
    issue(r_inst(FN_JALR, 5'd6, 5'd0, 5'd31, 5'd0), '0);
    finish_test();

    start_test("imm_branch_jump");
    issue(imm_inst(OPC_ADDI, 5'd1, 5'd20, 16'hfff0), '0);
    issue(imm_inst(OPC_SLTI, 5'd2, 5'd21, 16'h8000), '0);
    issue(imm_inst(OPC_SLTIU, 5'd3, 5'd22, 16'h7fff), '0);
    issue(imm_inst(OPC_ANDI, 5'd4, 5'd23, 16'h8001), '0);
    issue(imm_inst(OPC_XORI, 5'd5, 5'd24, 16'hc3c3), '0);
    issue(imm_inst(OPC_LUI, 5'd0, 5'd25, 16'h1234), '0);
    issue(imm_inst(OPC_BEQ, 5'd1, 5'd2, 16'hfffe), '0);
    issue(imm_inst(OPC_BNE, 5'd3, 5'd4, 16'h0010), '0);
    issue(imm_inst(OPC_BLEZ, 5'd5, 5'd0, 16'h8000), '0);
    issue(imm_inst(OPC_BGTZ, 5'd6, 5'd0, 16'h0003), '0);
    issue(imm_inst(OPC_REGIMM, 5'd1, RT_BLTZ, 16'hfff8), '0);
    issue(imm_inst(OPC_REGIMM, 5'd2, RT_BGEZ, 16'h0004), '0);
    issue(imm_inst(OPC_REGIMM, 5'd3, RT_BLTZAL, 16'h0100), '0);
    issue(imm_inst(OPC_REGIMM, 5'd4, RT_BGEZAL, 16'hff00), '0);
    issue(jump_inst(OPC_J, 26'h123_4567), '0);
    issue(jump_inst(OPC_JAL, 26'h3ff_ffff), '0);
    finish_test();

    start_test("load_store");
    issue(imm_inst(OPC_LB, 5'd1, 5'd22, 16'h8004), '0);
    issue(imm_inst(OPC_LH, 5'd2, 5'd23, 16'h0002), '0);
    issue(imm_inst(OPC_LW, 5'd3, 5'd24, 16'hfffc), '0);
    issue(imm_inst(OPC_LBU, 5'd4, 5'd25, 16'h0001), '0);
    issue(imm_inst(OPC_LHU, 5'd5, 5'd26, 16'h7ffe), '0);
    issue(imm_inst(OPC_SB, 5'd1, 5'd2, 16'h0008), '0);
    issue(imm_inst(OPC_SH, 5'd3, 5'd4, 16'h8000), '0);
    issue(imm_inst(OPC_SW, 5'd5, 5'd6, 16'h0010), '0);
    issue(imm_inst(6'h3f, 5'd1, 5'd2, 16'h1234), '0); // no such opcode
    issue(r_inst(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0), '0);
    issue(imm_inst(OPC_REGIMM, 5'd1, 5'h05, 16'h0004), '0);
    finish_test();

    start_test("forwarding");
    rx = 5'd16 | 5'($random(seed));
    issue(r_inst(FN_ADD, 5'd1, 5'd2, rx, 5'd0), '0);
    issue(r_inst(FN_ADD, rx, rx, 5'd9, 5'd0), '0);
    issue(r_inst(FN_SUB, 5'd3, 5'd4, 5'd8, 5'd0), producer(5'd3));
    issue(r_inst(FN_OR, 5'd8, 5'd3, 5'd10, 5'd0), producer(5'd3));
    issue(r_inst(FN_AND, 5'd10, 5'd5, 5'd11, 5'd0), producer(5'd10)); // EX beats MEM
    issue(r_inst(FN_SLL, 5'd11, 5'd1, 5'd12, 5'd4), producer(5'd11));
    issue(r_inst(FN_JR, 5'd2, 5'd12, 5'd0, 5'd0), '0);
    finish_test();

    start_test("load_use");
    issue(imm_inst(OPC_LW, 5'd1, 5'd12, 16'h0000), '0);
    issue(r_inst(FN_ADD, 5'd12, 5'd2, 5'd13, 5'd0), producer(5'd12));
    issue(imm_inst(OPC_LH, 5'd2, 5'd14, 16'h0002), '0);
    issue(r_inst(FN_OR, 5'd3, 5'd14, 5'd15, 5'd0), producer(5'd14));
    check_word("stall_cycles", 32'd2, 32'(stall_cycles));
    finish_test();

    start_test("load_store_late");
    issue(imm_inst(OPC_LW, 5'd2, 5'd16, 16'h0000), '0);
    issue(imm_inst(OPC_SW, 5'd1, 5'd16, 16'h0004), '0);
    check_word("stall_cycles", 32'd0, 32'(stall_cycles));
    finish_test();

    $display("%0d tests run, %0d errors", tests_run, total_errs);
    if (total_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/hazard_unit.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
verification/decode_stage_props.sv
verification/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module decode_stage_tb -f all.f
./obj_dir/Vdecode_stage_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
